// File: hw/decodeStage_params.svh
`ifndef DECODE_STAGE_PARAMS_SVH
`define DECODE_STAGE_PARAMS_SVH

// Datapath word, also used for addresses
`define XLEN 32

`define INSTRUCTION_WIDTH 32

// Register file index
`define REGISTER_ADDRESS_WIDTH 5

// Instruction field widths
`define OPCODE_WIDTH 7
`define FUNCT3_WIDTH 3
`define FUNCT7_WIDTH 7

`endif

// File: hw/decodePkg.sv
`include "decodeStage_params.svh"

package decodePkg;

    typedef logic [`XLEN-1:0] wordT;
    typedef logic [`INSTRUCTION_WIDTH-1:0] instructionT;
    typedef logic [`REGISTER_ADDRESS_WIDTH-1:0] registerAddressT;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        OPCODE_LOAD     = 7'b0000011,
        OPCODE_MISC_MEM = 7'b0001111, // FENCE, FENCE.I
        OPCODE_ALU_IMM  = 7'b0010011,
        OPCODE_AUIPC    = 7'b0010111,
        OPCODE_STORE    = 7'b0100011,
        OPCODE_ALU_REG  = 7'b0110011,
        OPCODE_LUI      = 7'b0110111,
        OPCODE_BRANCH   = 7'b1100011,
        OPCODE_JALR     = 7'b1100111,
        OPCODE_JAL      = 7'b1101111,
        OPCODE_SYSTEM   = 7'b1110011  // Always illegal in this core
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } aluOperationT;

    typedef enum logic [1:0] {ALU_RS1_RS2, ALU_RS1_IMM, ALU_PC_IMM, ALU_ZERO_IMM} aluSourceT;

    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PC4} writebackT;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU} branchT;

    typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_JALR} jumpT;

    // Byte and half follow funct3 and word sets both bits
    typedef enum logic [1:0] {MEM_BYTE = 2'b00, MEM_HALF = 2'b01, MEM_WORD = 2'b11} memoryWidthT;

    typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immediateFormatT;

    typedef enum logic [1:0] {TRAP_NONE, TRAP_ILLEGAL, TRAP_ACCESS_INST} trapT;

endpackage

// File: hw/decodeControlIf.sv
`timescale 1ns/1ps

interface decodeControlIf import decodePkg::*; ();

    registerAddressT destination;
    aluSourceT aluSource;
    aluOperationT aluOperation;
    writebackT writeback;
    logic memoryRead;
    logic memoryWrite;
    memoryWidthT memoryWidth;
    logic memorySigned;
    branchT branch;
    jumpT jump;
    logic illegal; // Raw decode verdict, before fault priority

    modport decoder (
        output destination, aluSource, aluOperation, writeback,
        output memoryRead, memoryWrite, memoryWidth, memorySigned,
        output branch, jump, illegal
    );

    modport stage (
        input destination, aluSource, aluOperation, writeback,
        input memoryRead, memoryWrite, memoryWidth, memorySigned,
        input branch, jump, illegal
    );

endinterface

// File: hw/instructionDecoder.sv
`timescale 1ns/1ps
`include "decodeStage_params.svh"

module instructionDecoder import decodePkg::*; (
    input instructionT instruction,
    output registerAddressT readAddress1,
    output registerAddressT readAddress2,
    output immediateFormatT immediateFormat,
    decodeControlIf.decoder control
);

    opcodeT opcode;
    logic [`FUNCT3_WIDTH-1:0] funct3;
    logic [`FUNCT7_WIDTH-1:0] funct7;
    registerAddressT destinationField;
    registerAddressT source1Field;
    registerAddressT source2Field;

    assign opcode = opcodeT'(instruction[`OPCODE_WIDTH-1:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign destinationField = instruction[11:7];
    assign source1Field = instruction[19:15];
    assign source2Field = instruction[24:20];

    always_comb begin
        control.destination = '0;
        control.aluSource = ALU_RS1_RS2;
        control.aluOperation = ALU_ADD;
        control.writeback = WB_NONE;
        control.memoryRead = 1'b0;
        control.memoryWrite = 1'b0;
        control.memoryWidth = MEM_BYTE;
        control.memorySigned = 1'b0;
        control.branch = BR_NONE;
        control.jump = JUMP_NONE;
        control.illegal = 1'b0;
        readAddress1 = '0;
        readAddress2 = '0;
        immediateFormat = IMM_NONE;
        unique case (opcode)
            OPCODE_ALU_REG: begin
                control.destination = destinationField;
                control.writeback = WB_ALU;
                readAddress1 = source1Field;
                readAddress2 = source2Field;
                unique case ({funct7, funct3})
                    10'b0000000_000: control.aluOperation = ALU_ADD;
                    10'b0100000_000: control.aluOperation = ALU_SUB;
                    10'b0000000_111: control.aluOperation = ALU_AND;
                    10'b0000000_110: control.aluOperation = ALU_OR;
                    10'b0000000_100: control.aluOperation = ALU_XOR;
                    10'b0000000_001: control.aluOperation = ALU_SLL;
                    10'b0000000_101: control.aluOperation = ALU_SRL;
                    10'b0100000_101: control.aluOperation = ALU_SRA;
                    10'b0000000_010: control.aluOperation = ALU_SLT;
                    10'b0000000_011: control.aluOperation = ALU_SLTU;
                    default: control.illegal = 1'b1;
                endcase
            end
            OPCODE_ALU_IMM: begin
                control.destination = destinationField;
                control.aluSource = ALU_RS1_IMM;
                control.writeback = WB_ALU;
                readAddress1 = source1Field;
                immediateFormat = IMM_I;
                unique case (funct3)
                    3'b000: control.aluOperation = ALU_ADD;
                    3'b010: control.aluOperation = ALU_SLT;
                    3'b011: control.aluOperation = ALU_SLTU;
                    3'b100: control.aluOperation = ALU_XOR;
                    3'b110: control.aluOperation = ALU_OR;
                    3'b111: control.aluOperation = ALU_AND;
                    3'b001: begin
                        control.aluOperation = ALU_SLL;
                        control.illegal = (funct7 != 7'b0000000); // Shamt above 31 too
                    end
                    default: begin // SRLI and SRAI share funct3
                        control.aluOperation = funct7[5] ? ALU_SRA : ALU_SRL;
                        control.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
            end
            OPCODE_LOAD: begin
                control.destination = destinationField;
                control.aluSource = ALU_RS1_IMM;
                control.writeback = WB_MEM;
                control.memoryRead = 1'b1;
                readAddress1 = source1Field;
                immediateFormat = IMM_I;
                control.memorySigned = !funct3[2]; // LBU and LHU set bit 2
                unique case (funct3)
                    3'b000, 3'b100: control.memoryWidth = MEM_BYTE;
                    3'b001, 3'b101: control.memoryWidth = MEM_HALF;
                    3'b010: control.memoryWidth = MEM_WORD;
                    default: control.illegal = 1'b1;
                endcase
            end
            OPCODE_STORE: begin
                control.aluSource = ALU_RS1_IMM;
                control.memoryWrite = 1'b1;
                readAddress1 = source1Field;
                readAddress2 = source2Field;
                immediateFormat = IMM_S;
                unique case (funct3)
                    3'b000: control.memoryWidth = MEM_BYTE;
                    3'b001: control.memoryWidth = MEM_HALF;
                    3'b010: control.memoryWidth = MEM_WORD;
                    default: control.illegal = 1'b1;
                endcase
            end
            OPCODE_BRANCH: begin
                control.aluSource = ALU_PC_IMM; // Target address
                readAddress1 = source1Field;
                readAddress2 = source2Field;
                immediateFormat = IMM_B;
                unique case (funct3)
                    3'b000: control.branch = BR_EQ;
                    3'b001: control.branch = BR_NE;
                    3'b100: control.branch = BR_LT;
                    3'b101: control.branch = BR_GE;
                    3'b110: control.branch = BR_LTU;
                    3'b111: control.branch = BR_GEU;
                    default: control.illegal = 1'b1;
                endcase
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                control.destination = destinationField;
                control.aluSource = (opcode == OPCODE_LUI) ? ALU_ZERO_IMM : ALU_PC_IMM;
                control.writeback = WB_ALU;
                immediateFormat = IMM_U;
            end
            OPCODE_JAL: begin
                control.destination = destinationField;
                control.aluSource = ALU_PC_IMM;
                control.writeback = WB_PC4;
                control.jump = JUMP_JAL;
                immediateFormat = IMM_J;
            end
            OPCODE_JALR: begin
                control.destination = destinationField;
                control.aluSource = ALU_RS1_IMM;
                control.writeback = WB_PC4;
                control.jump = JUMP_JALR;
                readAddress1 = source1Field;
                immediateFormat = IMM_I;
                control.illegal = (funct3 != 3'b000);
            end
            OPCODE_MISC_MEM: control.illegal = funct3[2:1] != 2'b00; // Fences retire as no-ops
            default: control.illegal = 1'b1; // SYSTEM and unknown opcodes
        endcase
    end

    always_comb begin
        assert final (!(control.memoryRead && control.memoryWrite))
            else $error("Decode asserts load and store together");
    end

endmodule

// File: hw/immediateGenerator.sv
`timescale 1ns/1ps
`include "decodeStage_params.svh"

module immediateGenerator import decodePkg::*; (
    input instructionT instruction,
    input immediateFormatT immediateFormat,
    output wordT immediate
);

    logic sign;

    assign sign = instruction[31];

    always_comb begin
        unique case (immediateFormat)
            IMM_I: immediate = {{(`XLEN-12){sign}}, instruction[31:20]};
            IMM_S: immediate = {{(`XLEN-12){sign}}, instruction[31:25], instruction[11:7]};
            IMM_B: begin
                immediate = {{(`XLEN-12){sign}}, instruction[7], instruction[30:25],
                             instruction[11:8], 1'b0};
            end
            IMM_U: immediate = {instruction[31:12], 12'd0}; // Low bits are zero
            IMM_J: begin
                immediate = {{(`XLEN-20){sign}}, instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};
            end
            default: immediate = '0;
        endcase
    end

endmodule

// File: hw/decodeRegister.sv
`timescale 1ns/1ps

module decodeRegister import decodePkg::*; (
    input logic clock,
    input logic reset,
    input logic fetchValid,
    input logic fetchAccessFault,
    input instructionT fetchInstruction,
    input wordT fetchProgramCounter,
    input logic stall,
    input logic flush,
    decodeControlIf.stage control,
    input registerAddressT readAddress1,
    input registerAddressT readAddress2,
    input wordT readData1,
    input wordT readData2,
    input wordT immediate,
    output logic decodeValid,
    output registerAddressT decodeDestination,
    output registerAddressT decodeSource1,
    output registerAddressT decodeSource2,
    output aluSourceT decodeAluSource,
    output aluOperationT decodeAluOperation,
    output writebackT decodeWriteback,
    output logic decodeMemoryRead,
    output logic decodeMemoryWrite,
    output memoryWidthT decodeMemoryWidth,
    output logic decodeMemorySigned,
    output branchT decodeBranch,
    output jumpT decodeJump,
    output wordT decodeImmediate,
    output wordT decodeRegisterData1,
    output wordT decodeRegisterData2,
    output wordT decodeProgramCounter,
    output trapT decodeTrap,
    output wordT decodeFaultAddress
);

    trapT nextTrap;
    wordT nextFaultAddress;
    logic trapped;

    always_comb begin
        nextTrap = TRAP_NONE;
        nextFaultAddress = '0;
        if (fetchAccessFault) begin // Fetch fault outranks any decode result
            nextTrap = TRAP_ACCESS_INST;
            nextFaultAddress = fetchProgramCounter;
        end else if (control.illegal) begin
            nextTrap = TRAP_ILLEGAL;
            nextFaultAddress = wordT'(fetchInstruction);
        end
    end

    assign trapped = (nextTrap != TRAP_NONE);

    always_ff @(posedge clock) begin
        if (reset || (!flush && !stall && !fetchValid)) begin // Bubble loads zeros
            decodeValid <= 1'b0;
            decodeDestination <= '0;
            decodeSource1 <= '0;
            decodeSource2 <= '0;
            decodeAluSource <= ALU_RS1_RS2;
            decodeAluOperation <= ALU_ADD;
            decodeWriteback <= WB_NONE;
            decodeMemoryRead <= 1'b0;
            decodeMemoryWrite <= 1'b0;
            decodeMemoryWidth <= MEM_BYTE;
            decodeMemorySigned <= 1'b0;
            decodeBranch <= BR_NONE;
            decodeJump <= JUMP_NONE;
            decodeImmediate <= '0;
            decodeRegisterData1 <= '0;
            decodeRegisterData2 <= '0;
            decodeProgramCounter <= '0;
            decodeTrap <= TRAP_NONE;
            decodeFaultAddress <= '0;
        end else if (flush) begin
            decodeValid <= 1'b0; // Payload keeps old values
        end else if (!stall) begin
            decodeValid <= 1'b1;
            decodeDestination <= trapped ? '0 : control.destination;
            decodeSource1 <= readAddress1;
            decodeSource2 <= readAddress2;
            decodeAluSource <= control.aluSource;
            decodeAluOperation <= control.aluOperation;
            decodeWriteback <= trapped ? WB_NONE : control.writeback;
            decodeMemoryRead <= control.memoryRead && !trapped;
            decodeMemoryWrite <= control.memoryWrite && !trapped;
            decodeMemoryWidth <= control.memoryWidth;
            decodeMemorySigned <= control.memorySigned;
            decodeBranch <= control.branch;
            decodeJump <= control.jump;
            decodeImmediate <= immediate;
            decodeRegisterData1 <= readData1;
            decodeRegisterData2 <= readData2;
            decodeProgramCounter <= fetchProgramCounter;
            decodeTrap <= nextTrap;
            decodeFaultAddress <= nextFaultAddress;
        end
    end

    assert property (@(posedge clock) disable iff (reset) flush |=> !decodeValid)
        else $error("Flush did not drop decodeValid");

    // Squashed instructions must never reach writeback
    assert property (@(posedge clock) disable iff (reset)
        (decodeTrap != TRAP_NONE) |-> (decodeWriteback == WB_NONE))
        else $error("Trapping instruction carries a writeback");

endmodule

// File: hw/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import decodePkg::*; (
    input logic clock,
    input logic reset,
    input logic fetchValid,
    input instructionT fetchInstruction,
    input wordT fetchProgramCounter,
    input logic fetchAccessFault,
    input logic stall,
    input logic flush,
    output registerAddressT readAddress1,
    output registerAddressT readAddress2,
    input wordT readData1,
    input wordT readData2,
    output logic decodeValid,
    output registerAddressT decodeDestination,
    output registerAddressT decodeSource1,
    output registerAddressT decodeSource2,
    output aluSourceT decodeAluSource,
    output aluOperationT decodeAluOperation,
    output writebackT decodeWriteback,
    output logic decodeMemoryRead,
    output logic decodeMemoryWrite,
    output memoryWidthT decodeMemoryWidth,
    output logic decodeMemorySigned,
    output branchT decodeBranch,
    output jumpT decodeJump,
    output wordT decodeImmediate,
    output wordT decodeRegisterData1,
    output wordT decodeRegisterData2,
    output wordT decodeProgramCounter,
    output trapT decodeTrap,
    output wordT decodeFaultAddress
);

    immediateFormatT immediateFormat;
    wordT immediate;

    decodeControlIf controlBus ();

    instructionDecoder decoder0 (
        .instruction(fetchInstruction),
        .readAddress1(readAddress1), // Register file reads in the same cycle
        .readAddress2(readAddress2),
        .immediateFormat(immediateFormat),
        .control(controlBus.decoder)
    );

    immediateGenerator immediateGenerator0 (
        .instruction(fetchInstruction),
        .immediateFormat(immediateFormat),
        .immediate(immediate)
    );

    decodeRegister decodeRegister0 (.*, .control(controlBus.stage));

endmodule

// File: verification/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb import decodePkg::*; ();

    localparam int RECORD_WORDS = 23; // 6 stimulus columns, 17 expected
    localparam int MAX_RECORDS = 64;
    localparam int FIELD_COUNT = 19; // Expected columns plus both register data words
    localparam int RESET_CYCLES = 5;
    localparam int RESET_TIMEOUT = 10;
    localparam logic [31:0] END_MARKER = 32'hff;

    logic clock;
    logic reset;
    logic fetchValid;
    logic fetchAccessFault;
    logic stall;
    logic flush;
    instructionT fetchInstruction;
    wordT fetchProgramCounter;
    registerAddressT readAddress1;
    registerAddressT readAddress2;
    wordT readData1;
    wordT readData2;
    logic decodeValid;
    registerAddressT decodeDestination;
    registerAddressT decodeSource1;
    registerAddressT decodeSource2;
    aluSourceT decodeAluSource;
    aluOperationT decodeAluOperation;
    writebackT decodeWriteback;
    logic decodeMemoryRead;
    logic decodeMemoryWrite;
    memoryWidthT decodeMemoryWidth;
    logic decodeMemorySigned;
    branchT decodeBranch;
    jumpT decodeJump;
    wordT decodeImmediate;
    wordT decodeRegisterData1;
    wordT decodeRegisterData2;
    wordT decodeProgramCounter;
    trapT decodeTrap;
    wordT decodeFaultAddress;

    logic [31:0] golden [0:RECORD_WORDS*MAX_RECORDS-1];
    logic [31:0] expected [0:FIELD_COUNT-1];

    decodeStage dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Register file model, answers in the same cycle
    function automatic wordT registerValue(input registerAddressT address);
        return 32'h1000_0000 + wordT'(address) * 32'h0101_0101;
    endfunction

    assign readData1 = registerValue(readAddress1);
    assign readData2 = registerValue(readAddress2);

    task automatic checkValue(input string name, input logic [31:0] want,
                              input logic [31:0] got);
        if (got !== want) begin
            $display("MISMATCH at %0d ns: %s expected %h, got %h", $time, name, want, got);
            $display("Finished with errors");
            $fatal(1, "Output check failed");
        end
    endtask

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Run aborted");
    endtask

    task automatic checkOutputs();
        checkValue("decodeValid", expected[0], decodeValid);
        checkValue("decodeDestination", expected[1], decodeDestination);
        checkValue("decodeSource1", expected[2], decodeSource1);
        checkValue("decodeSource2", expected[3], decodeSource2);
        checkValue("decodeAluSource", expected[4], decodeAluSource);
        checkValue("decodeAluOperation", expected[5], decodeAluOperation);
        checkValue("decodeWriteback", expected[6], decodeWriteback);
        checkValue("decodeMemoryRead", expected[7], decodeMemoryRead);
        checkValue("decodeMemoryWrite", expected[8], decodeMemoryWrite);
        checkValue("decodeMemoryWidth", expected[9], decodeMemoryWidth);
        checkValue("decodeMemorySigned", expected[10], decodeMemorySigned);
        checkValue("decodeBranch", expected[11], decodeBranch);
        checkValue("decodeJump", expected[12], decodeJump);
        checkValue("decodeImmediate", expected[13], decodeImmediate);
        checkValue("decodeProgramCounter", expected[14], decodeProgramCounter);
        checkValue("decodeTrap", expected[15], decodeTrap);
        checkValue("decodeFaultAddress", expected[16], decodeFaultAddress);
        checkValue("decodeRegisterData1", expected[17], decodeRegisterData1);
        checkValue("decodeRegisterData2", expected[18], decodeRegisterData2);
    endtask

    // Read ports follow the instruction still on the inputs
    task automatic checkReadAddresses(input int base);
        if (golden[base][0] && !golden[base+2][0] && !golden[base+3][0]) begin
            checkValue("readAddress1", golden[base+8], readAddress1);
            checkValue("readAddress2", golden[base+9], readAddress2);
        end
    endtask

    task automatic applyRecord(input int base);
        fetchValid = golden[base][0];
        fetchAccessFault = golden[base+1][0];
        stall = golden[base+2][0];
        flush = golden[base+3][0];
        fetchInstruction = golden[base+4];
        fetchProgramCounter = golden[base+5];
    endtask

    // Flush beats stall, stall beats load, a bubble loads zeros
    task automatic updateExpected(input int base);
        if (golden[base+3][0]) begin
            expected[0] = '0; // Payload stays
        end else if (!golden[base+2][0]) begin
            if (!golden[base][0]) begin
                for (int i = 0; i < FIELD_COUNT; i++) begin
                    expected[i] = '0;
                end
            end else begin
                for (int i = 0; i < FIELD_COUNT - 2; i++) begin
                    expected[i] = golden[base+6+i];
                end
                expected[17] = registerValue(expected[2][4:0]);
                expected[18] = registerValue(expected[3][4:0]);
            end
        end
    endtask

    initial begin
        int record;
        int cycles;
        reset = 1'b1;
        fetchValid = 1'b0;
        fetchAccessFault = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        fetchInstruction = '0;
        fetchProgramCounter = '0;
        $readmemh("verification/decodeStageGolden.txt", golden);
        if ($isunknown(golden[0])) begin
            failRun("The golden file could not be read");
        end
        cycles = 0;
        while (cycles < RESET_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        reset = 1'b0;
        cycles = 0;
        while (decodeValid !== 1'b0 || decodeTrap !== TRAP_NONE) begin
            if (cycles == RESET_TIMEOUT) begin
                failRun("The decode outputs did not clear after reset");
            end else begin
                @(negedge clock);
                cycles++;
            end
        end
        for (int i = 0; i < FIELD_COUNT; i++) begin
            expected[i] = '0;
        end
        checkOutputs();
        record = 0;
        while (golden[record*RECORD_WORDS] !== END_MARKER) begin
            if (record == MAX_RECORDS) begin
                failRun("The golden file has no end marker");
            end else begin
                applyRecord(record * RECORD_WORDS);
                @(negedge clock); // One rising edge in between
                checkReadAddresses(record * RECORD_WORDS);
                updateExpected(record * RECORD_WORDS);
                checkOutputs();
                record++;
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: verification/decodeStageGolden.txt
// fetchValid fault stall flush instruction pc | valid dest src1 src2 aluSrc aluOp wb
// memRead memWrite memWidth memSigned branch jump immediate pc trap faultAddress
// Expected columns are unused on stall, flush and bubble lines; ff ends the records
1 0 0 0 40628233 00001000 1 04 05 06 0 1 1 0 0 0 0 0 0 00000000 00001000 0 00000000
1 0 0 0 009413b3 00001004 1 07 08 09 0 5 1 0 0 0 0 0 0 00000000 00001004 0 00000000
1 0 0 0 0020b533 00001008 1 0a 01 02 0 9 1 0 0 0 0 0 0 00000000 00001008 0 00000000
1 0 0 0 00d675b3 0000100c 1 0b 0c 0d 0 2 1 0 0 0 0 0 0 00000000 0000100c 0 00000000
1 0 0 0 ffb10093 00001010 1 01 02 00 1 0 1 0 0 0 0 0 0 fffffffb 00001010 0 00000000
1 0 0 0 7ff24193 00001014 1 03 04 00 1 4 1 0 0 0 0 0 0 000007ff 00001014 0 00000000
1 0 0 0 0f036293 00001018 1 05 06 00 1 3 1 0 0 0 0 0 0 000000f0 00001018 0 00000000
1 0 0 0 fff3a313 0000101c 1 06 07 00 1 8 1 0 0 0 0 0 0 ffffffff 0000101c 0 00000000
1 0 0 0 0034d413 00001020 1 08 09 00 1 6 1 0 0 0 0 0 0 00000003 00001020 0 00000000
1 0 0 0 41f55493 00001024 1 09 0a 00 1 7 1 0 0 0 0 0 0 0000041f 00001024 0 00000000
1 0 0 0 00410083 00001028 1 01 02 00 1 0 2 1 0 0 1 0 0 00000004 00001028 0 00000000
1 0 0 0 ffe19103 0000102c 1 02 03 00 1 0 2 1 0 1 1 0 0 fffffffe 0000102c 0 00000000
1 0 0 0 00822183 00001030 1 03 04 00 1 0 2 1 0 3 1 0 0 00000008 00001030 0 00000000
1 0 0 0 0012c203 00001034 1 04 05 00 1 0 2 1 0 0 0 0 0 00000001 00001034 0 00000000
1 0 0 0 00235283 00001038 1 05 06 00 1 0 2 1 0 1 0 0 0 00000002 00001038 0 00000000
1 0 0 0 00742623 0000103c 1 00 08 07 1 0 0 0 1 3 0 0 0 0000000c 0000103c 0 00000000
1 0 0 0 fe950fa3 00001040 1 00 0a 09 1 0 0 0 1 0 0 0 0 ffffffff 00001040 0 00000000
1 0 0 0 00208463 00001044 1 00 01 02 2 0 0 0 0 0 0 1 0 00000008 00001044 0 00000000
1 0 0 0 fe419ee3 00001048 1 00 03 04 2 0 0 0 0 0 0 2 0 fffffffc 00001048 0 00000000
1 0 0 0 0062c463 0000104c 1 00 05 06 2 0 0 0 0 0 0 3 0 00000008 0000104c 0 00000000
1 0 0 0 0083d463 00001050 1 00 07 08 2 0 0 0 0 0 0 4 0 00000008 00001050 0 00000000
1 0 0 0 00a4e463 00001054 1 00 09 0a 2 0 0 0 0 0 0 5 0 00000008 00001054 0 00000000
1 0 0 0 00c5f463 00001058 1 00 0b 0c 2 0 0 0 0 0 0 6 0 00000008 00001058 0 00000000
1 0 0 0 abcde6b7 0000105c 1 0d 00 00 3 0 1 0 0 0 0 0 0 abcde000 0000105c 0 00000000
1 0 0 0 12345717 00001060 1 0e 00 00 2 0 1 0 0 0 0 0 0 12345000 00001060 0 00000000
1 0 0 0 ff1ff0ef 00001064 1 01 00 00 2 0 3 0 0 0 0 0 1 fffffff0 00001064 0 00000000
1 0 0 0 004302e7 00001068 1 05 06 00 1 0 3 0 0 0 0 0 2 00000004 00001068 0 00000000
1 0 0 0 0ff0000f 0000106c 1 00 00 00 0 0 0 0 0 0 0 0 0 00000000 0000106c 0 00000000
1 0 0 0 022081b3 00001070 1 00 01 02 0 0 0 0 0 0 0 0 0 00000000 00001070 1 022081b3
1 0 0 0 02111093 00001074 1 00 02 00 1 5 0 0 0 0 0 0 0 00000021 00001074 1 02111093
1 0 0 0 004312e7 00001078 1 00 06 00 1 0 0 0 0 0 0 0 2 00000004 00001078 1 004312e7
1 0 0 0 00000073 0000107c 1 00 00 00 0 0 0 0 0 0 0 0 0 00000000 0000107c 1 00000073
1 0 0 0 12345657 00001080 1 00 00 00 0 0 0 0 0 0 0 0 0 00000000 00001080 1 12345657
1 1 0 0 ffb10093 00001084 1 00 02 00 1 0 0 0 0 0 0 0 0 fffffffb 00001084 2 00001084
1 1 0 0 00000073 00001088 1 00 00 00 0 0 0 0 0 0 0 0 0 00000000 00001088 2 00001088
1 0 0 0 00822183 0000108c 1 03 04 00 1 0 2 1 0 3 1 0 0 00000008 0000108c 0 00000000
1 0 1 0 40628233 00001090 0 00 00 00 0 0 0 0 0 0 0 0 0 00000000 00000000 0 00000000
1 0 1 0 40628233 00001090 0 00 00 00 0 0 0 0 0 0 0 0 0 00000000 00000000 0 00000000
1 0 1 1 40628233 00001090 0 00 00 00 0 0 0 0 0 0 0 0 0 00000000 00000000 0 00000000
0 0 0 0 40628233 00001094 0 00 00 00 0 0 0 0 0 0 0 0 0 00000000 00000000 0 00000000
1 0 0 0 ffb10093 00001098 1 01 02 00 1 0 1 0 0 0 0 0 0 fffffffb 00001098 0 00000000
ff

// File: rvDecodeStage.f
+incdir+hw
hw/decodePkg.sv
hw/decodeControlIf.sv
hw/instructionDecoder.sv
hw/immediateGenerator.sv
hw/decodeRegister.sv
hw/decodeStage.sv
verification/decodeStageTb.sv
